/* include/plic_config.svh */
`ifndef PLIC_CONFIG_SVH
`define PLIC_CONFIG_SVH

// Source vector width, bit 0 is the reserved "none" ID
`define PLIC_NUM_SRC 32
`define PLIC_PRIO_BITS 3
`define PLIC_SYNC_STAGES 2

// ******************************
// Register map
// ******************************
`define PLIC_ADDR_BITS 12
`define PLIC_OFS_PRIO 12'h000
`define PLIC_OFS_PENDING 12'h080
`define PLIC_OFS_ENABLE 12'h100
`define PLIC_OFS_THRESHOLD 12'h200
`define PLIC_OFS_CLAIM 12'h204

// ******************************
// Source map, first ID of each group
// ******************************
`define PLIC_MAP_UART_LO 1
`define PLIC_MAP_SPI 5
`define PLIC_MAP_I2C_LO 6
`define PLIC_MAP_GPIO_LO 8
`define PLIC_MAP_USER_LO 16

`endif

/* logic/plic_pkg.sv */
`include "plic_config.svh"

package plic_pkg;

	// Source ID, 0 means no interrupt
	typedef logic [$clog2(`PLIC_NUM_SRC)-1:0] src_id_t;

	// Priority and threshold level
	typedef logic [`PLIC_PRIO_BITS-1:0] prio_t;

	// AXI4-Lite response codes in use
	typedef enum logic [1:0]
	{
		OKAY = 2'b00,
		SLVERR = 2'b10
	} axi_resp_t;

endpackage

/* logic/irq_synchronizer.sv */
`timescale 1ns/1ps

module irq_synchronizer
#(
	parameter int STAGES = 2
)
(
	input logic clk,
	input logic rst,
	input logic [31:0] async_in,
	output logic [31:0] sync_out
);

	logic [31:0] stage_q [STAGES];

	// Plain flop chain per bit, first stage may go metastable
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < STAGES; i++)
			begin
				stage_q[i] <= '0;
			end
		end
		else
		begin
			stage_q[0] <= async_in;
			for (int i = 1; i < STAGES; i++)
			begin
				stage_q[i] <= stage_q[i-1];
			end
		end
	end

	assign sync_out = stage_q[STAGES-1];

endmodule

/* logic/plic_gateway.sv */
`timescale 1ns/1ps
`include "plic_config.svh"

module plic_gateway
(
	input logic clk,
	input logic rst,
	input logic [31:0] sync_irq,
	input logic claim_valid,
	input plic_pkg::src_id_t claim_id,
	input logic complete_valid,
	input plic_pkg::src_id_t complete_id,
	output logic [31:0] pending
);

	logic [31:0] in_service_q;
	logic [31:0] pending_d;
	logic [31:0] in_service_d;

	always_comb
	begin
		pending_d = pending;
		in_service_d = in_service_q;

		// Level sources latch only when idle
		for (int i = 1; i < `PLIC_NUM_SRC; i++)
		begin
			if (sync_irq[i] && !pending[i] && !in_service_q[i])
			begin
				pending_d[i] = 1'b1;
			end
		end

		if (complete_valid)
		begin
			in_service_d[complete_id] = 1'b0;
		end

		// Claim wins over a complete of the same ID
		if (claim_valid && (claim_id != '0))
		begin
			pending_d[claim_id] = 1'b0;
			in_service_d[claim_id] = 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pending <= '0;
			in_service_q <= '0;
		end
		else
		begin
			pending <= pending_d;
			in_service_q <= in_service_d;
		end
	end

	a_pend_serv_excl: assert property (@(posedge clk) disable iff (rst)
		(pending & in_service_q) == '0);

	a_id0_idle: assert property (@(posedge clk) disable iff (rst)
		!pending[0]);

endmodule

/* logic/plic_target.sv */
`timescale 1ns/1ps
`include "plic_config.svh"

module plic_target
(
	input logic clk,
	input logic rst,
	input logic [31:0] pending,
	input logic [31:0] enable,
	input logic [`PLIC_NUM_SRC*`PLIC_PRIO_BITS-1:0] prio_flat,
	input plic_pkg::prio_t threshold,
	output plic_pkg::src_id_t best_id,
	output logic hart_irq
);

	plic_pkg::prio_t best_prio;
	plic_pkg::prio_t cur_prio;

	// ******************************
	// Priority scan
	// ******************************

	// Strict compare keeps the lowest ID on ties and skips priority 0
	always_comb
	begin
		best_id = '0;
		best_prio = '0;
		cur_prio = '0;
		for (int i = 1; i < `PLIC_NUM_SRC; i++)
		begin
			cur_prio = prio_flat[i*`PLIC_PRIO_BITS +: `PLIC_PRIO_BITS];
			if (pending[i] && enable[i] && (cur_prio > best_prio))
			begin
				best_id = plic_pkg::src_id_t'(i);
				best_prio = cur_prio;
			end
		end
	end

	// ******************************
	// Hart interrupt
	// ******************************
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			hart_irq <= 1'b0;
		end
		else
		begin
			hart_irq <= (best_prio > threshold);
		end
	end

	a_irq_has_src: assert property (@(posedge clk) disable iff (rst)
		hart_irq |-> ($past(best_id) != '0));

endmodule

/* logic/plic_axil_regs.sv */
`timescale 1ns/1ps
`include "plic_config.svh"

module plic_axil_regs
(
	input logic clk,
	input logic rst,

	input logic [`PLIC_ADDR_BITS-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [31:0] wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	output plic_pkg::axi_resp_t bresp,
	output logic bvalid,
	input logic bready,
	input logic [`PLIC_ADDR_BITS-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output plic_pkg::axi_resp_t rresp,
	output logic rvalid,
	input logic rready,

	input logic [31:0] pending,
	input plic_pkg::src_id_t best_id,
	output logic [31:0] enable,
	output logic [`PLIC_NUM_SRC*`PLIC_PRIO_BITS-1:0] prio_flat,
	output plic_pkg::prio_t threshold,
	output logic claim_valid,
	output plic_pkg::src_id_t claim_id,
	output logic complete_valid,
	output plic_pkg::src_id_t complete_id
);

	localparam int AB = `PLIC_ADDR_BITS;

	plic_pkg::prio_t prio_q [`PLIC_NUM_SRC];

	logic aw_hs;
	logic ar_hs;
	logic wr_full;
	logic wr_prio;
	logic wr_err;
	logic rd_prio;
	logic rd_err;
	plic_pkg::src_id_t wr_id;
	plic_pkg::src_id_t rd_id;
	logic [31:0] rd_word;

	// True for a word-aligned offset inside the priority block
	function automatic logic in_prio(input logic [AB-1:0] addr);
		logic [AB-1:0] rel;
		rel = addr - `PLIC_OFS_PRIO;
		return (rel < `PLIC_NUM_SRC * 4) && (rel[1:0] == 2'b00);
	endfunction

	function automatic plic_pkg::src_id_t prio_id(input logic [AB-1:0] addr);
		logic [AB-1:0] rel;
		rel = addr - `PLIC_OFS_PRIO;
		return plic_pkg::src_id_t'(rel >> 2);
	endfunction

	assign aw_hs = awready && awvalid && wvalid;
	assign ar_hs = arready && arvalid;

	// ******************************
	// Write path
	// ******************************
	always_comb
	begin
		wr_prio = in_prio(awaddr);
		wr_id = prio_id(awaddr);
		wr_full = (wstrb == 4'hf);
		wr_err = 1'b1;
		if (wr_full)
		begin
			if (wr_prio)
			begin
				wr_err = (wr_id == '0);
			end
			else if ((awaddr == `PLIC_OFS_ENABLE) || (awaddr == `PLIC_OFS_THRESHOLD) ||
				(awaddr == `PLIC_OFS_CLAIM))
			begin
				wr_err = 1'b0;
			end
		end
	end

	// One pulse on both readys, next response waits for bready
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			awready <= 1'b0;
			bvalid <= 1'b0;
		end
		else
		begin
			awready <= awvalid && wvalid && !bvalid && !awready;
			if (aw_hs)
			begin
				bvalid <= 1'b1;
			end
			else if (bready)
			begin
				bvalid <= 1'b0;
			end
		end
	end

	assign wready = awready;

	always_ff @(posedge clk)
	begin
		if (aw_hs)
		begin
			bresp <= wr_err ? plic_pkg::SLVERR : plic_pkg::OKAY;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			enable <= '0;
			threshold <= '0;
			for (int i = 0; i < `PLIC_NUM_SRC; i++)
			begin
				prio_q[i] <= '0;
			end
		end
		else if (aw_hs && !wr_err)
		begin
			if (wr_prio)
			begin
				prio_q[wr_id] <= wdata[`PLIC_PRIO_BITS-1:0];
			end
			else if (awaddr == `PLIC_OFS_ENABLE)
			begin
				// No source behind ID 0
				enable <= {wdata[31:1], 1'b0};
			end
			else if (awaddr == `PLIC_OFS_THRESHOLD)
			begin
				threshold <= wdata[`PLIC_PRIO_BITS-1:0];
			end
		end
	end

	always_comb
	begin
		for (int i = 0; i < `PLIC_NUM_SRC; i++)
		begin
			prio_flat[i*`PLIC_PRIO_BITS +: `PLIC_PRIO_BITS] = prio_q[i];
		end
	end

	// Completing a disabled ID is dropped here
	assign complete_id = wdata[$bits(plic_pkg::src_id_t)-1:0];
	assign complete_valid = aw_hs && wr_full && (awaddr == `PLIC_OFS_CLAIM) &&
		enable[complete_id];

	// ******************************
	// Read path
	// ******************************
	always_comb
	begin
		rd_prio = in_prio(araddr);
		rd_id = prio_id(araddr);
		rd_word = '0;
		rd_err = 1'b0;
		if (rd_prio)
		begin
			rd_word = 32'(prio_q[rd_id]);
		end
		else
		begin
			case (araddr)
				`PLIC_OFS_PENDING: rd_word = pending;
				`PLIC_OFS_ENABLE: rd_word = enable;
				`PLIC_OFS_THRESHOLD: rd_word = 32'(threshold);
				`PLIC_OFS_CLAIM: rd_word = 32'(best_id);
				default: rd_err = 1'b1;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			arready <= 1'b0;
			rvalid <= 1'b0;
		end
		else
		begin
			arready <= arvalid && !rvalid && !arready;
			if (ar_hs)
			begin
				rvalid <= 1'b1;
			end
			else if (rready)
			begin
				rvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (ar_hs)
		begin
			rdata <= rd_word;
			rresp <= rd_err ? plic_pkg::SLVERR : plic_pkg::OKAY;
		end
	end

	// Claim takes effect in the accept cycle
	assign claim_valid = ar_hs && (araddr == `PLIC_OFS_CLAIM);
	assign claim_id = best_id;

	a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
		bvalid && !bready |=> bvalid && $stable(bresp));

	a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
		rvalid && !rready |=> rvalid && $stable(rdata));

	// A write is only accepted with no response outstanding
	a_aw_one_outstanding: assert property (@(posedge clk) disable iff (rst)
		awready |-> !bvalid);

endmodule

/* logic/plic_top.sv */
`timescale 1ns/1ps
`include "plic_config.svh"

module plic_top
(
	input logic clk,
	input logic rst,

	input logic [`PLIC_ADDR_BITS-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [31:0] wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	output plic_pkg::axi_resp_t bresp,
	output logic bvalid,
	input logic bready,
	input logic [`PLIC_ADDR_BITS-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output plic_pkg::axi_resp_t rresp,
	output logic rvalid,
	input logic rready,

	input logic [3:0] uart_irq,
	input logic spi_irq,
	input logic [1:0] i2c_irq,
	input logic [7:0] gpio_irq,
	input logic [15:0] user_irq,
	output logic hart_irq
);

	logic [31:0] raw_irq;
	logic [31:0] sync_irq;
	logic [31:0] pending;
	logic [31:0] enable;
	logic [`PLIC_NUM_SRC*`PLIC_PRIO_BITS-1:0] prio_flat;
	plic_pkg::prio_t threshold;
	plic_pkg::src_id_t best_id;
	logic claim_valid;
	plic_pkg::src_id_t claim_id;
	logic complete_valid;
	plic_pkg::src_id_t complete_id;

	// ******************************
	// Source map
	// ******************************
	always_comb
	begin
		raw_irq = '0;
		raw_irq[`PLIC_MAP_UART_LO +: $bits(uart_irq)] = uart_irq;
		raw_irq[`PLIC_MAP_SPI] = spi_irq;
		raw_irq[`PLIC_MAP_I2C_LO +: $bits(i2c_irq)] = i2c_irq;
		raw_irq[`PLIC_MAP_GPIO_LO +: $bits(gpio_irq)] = gpio_irq;
		raw_irq[`PLIC_MAP_USER_LO +: $bits(user_irq)] = user_irq;
	end

	irq_synchronizer
	#(
		.STAGES(`PLIC_SYNC_STAGES)
	)
	i_sync
	(
		.clk(clk),
		.rst(rst),
		.async_in(raw_irq),
		.sync_out(sync_irq)
	);

	plic_gateway i_gateway
	(
		.clk(clk),
		.rst(rst),
		.sync_irq(sync_irq),
		.claim_valid(claim_valid),
		.claim_id(claim_id),
		.complete_valid(complete_valid),
		.complete_id(complete_id),
		.pending(pending)
	);

	plic_target i_target
	(
		.clk(clk),
		.rst(rst),
		.pending(pending),
		.enable(enable),
		.prio_flat(prio_flat),
		.threshold(threshold),
		.best_id(best_id),
		.hart_irq(hart_irq)
	);

	// ******************************
	// Register slave
	// ******************************
	plic_axil_regs i_regs
	(
		.clk(clk),
		.rst(rst),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.pending(pending),
		.best_id(best_id),
		.enable(enable),
		.prio_flat(prio_flat),
		.threshold(threshold),
		.claim_valid(claim_valid),
		.claim_id(claim_id),
		.complete_valid(complete_valid),
		.complete_id(complete_id)
	);

endmodule

/* verification/plic_tb.sv */
`timescale 1ns/1ps
`include "plic_config.svh"

module plic_tb;

	localparam int ARB_ROUNDS = 12;
	localparam int BP_ROUNDS = 16;
	// Transactions and settles over all tests, each step well under 200 cycles
	localparam int NUM_STEPS = 80 + 31 * 6 + ARB_ROUNDS * 45 + 30 + 30 + BP_ROUNDS * 2;

	logic clk;
	logic rst;
	logic [`PLIC_ADDR_BITS-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	plic_pkg::axi_resp_t bresp;
	logic bvalid;
	logic bready;
	logic [`PLIC_ADDR_BITS-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	plic_pkg::axi_resp_t rresp;
	logic rvalid;
	logic rready;
	logic [3:0] uart_irq;
	logic spi_irq;
	logic [1:0] i2c_irq;
	logic [7:0] gpio_irq;
	logic [15:0] user_irq;
	logic hart_irq;

	integer seed;
	int max_delay;
	int mismatch_count;
	int proto_count;

	// Reference model state
	logic [31:0] m_line;
	logic [31:0] m_pending;
	logic [31:0] m_in_service;
	logic [31:0] m_enable;
	logic [`PLIC_NUM_SRC-1:0][`PLIC_PRIO_BITS-1:0] m_prio;
	logic [`PLIC_PRIO_BITS-1:0] m_threshold;

	// Checks waiting for the compare process
	string name_q[$];
	logic [31:0] got_q[$];
	logic [31:0] exp_q[$];

	plic_top i_dut
	(
		.clk(clk),
		.rst(rst),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.uart_irq(uart_irq),
		.spi_irq(spi_irq),
		.i2c_irq(i2c_irq),
		.gpio_irq(gpio_irq),
		.user_irq(user_irq),
		.hart_irq(hart_irq)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ******************************
	// Reference model
	// ******************************

	// Scan from the top ID down so the lowest ID keeps a tie
	function automatic logic [4:0] best_source(input logic [31:0] pend, input logic [31:0] en,
		input logic [`PLIC_NUM_SRC-1:0][`PLIC_PRIO_BITS-1:0] prio,
		input logic [`PLIC_PRIO_BITS-1:0] thr, output logic irq);
		logic [4:0] id;
		logic [`PLIC_PRIO_BITS-1:0] top;
		id = '0;
		top = '0;
		for (int i = `PLIC_NUM_SRC - 1; i >= 1; i--)
		begin
			if (pend[i] && en[i] && (prio[i] != 0) && (prio[i] >= top))
			begin
				id = i[4:0];
				top = prio[i];
			end
		end
		irq = (top > thr);
		return id;
	endfunction

	// Idle sources with a high line become pending
	task automatic latch_lines();
		m_pending = (m_pending | (m_line & ~m_in_service)) & ~32'h1;
	endtask

	// ******************************
	// Driving helpers
	// ******************************
	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic settle();
		repeat (6) tick();
		latch_lines();
	endtask

	task automatic expect_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		name_q.push_back(name);
		got_q.push_back(got);
		exp_q.push_back(exp);
	endtask

	task automatic set_line(input int grp, input int idx, input logic val);
		case (grp)
			0: uart_irq[idx] = val;
			1: spi_irq = val;
			2: i2c_irq[idx] = val;
			3: gpio_irq[idx] = val;
			default: user_irq[idx] = val;
		endcase
	endtask

	task automatic set_src(input int id, input logic val);
		m_line[id] = val;
		if (id >= `PLIC_MAP_USER_LO)
			set_line(4, id - `PLIC_MAP_USER_LO, val);
		else if (id >= `PLIC_MAP_GPIO_LO)
			set_line(3, id - `PLIC_MAP_GPIO_LO, val);
		else if (id >= `PLIC_MAP_I2C_LO)
			set_line(2, id - `PLIC_MAP_I2C_LO, val);
		else if (id == `PLIC_MAP_SPI)
			set_line(1, 0, val);
		else if (id >= `PLIC_MAP_UART_LO)
			set_line(0, id - `PLIC_MAP_UART_LO, val);
	endtask

	task automatic apply_lines(input logic [31:0] lines);
		for (int i = 1; i < `PLIC_NUM_SRC; i++)
			set_src(i, lines[i]);
	endtask

	task automatic reset_dut();
		apply_lines('0);
		rst = 1'b1;
		repeat (10) tick();
		rst = 1'b0;
		m_line = '0;
		m_pending = '0;
		m_in_service = '0;
		m_enable = '0;
		m_prio = '0;
		m_threshold = '0;
	endtask

	// ******************************
	// AXI4-Lite transactions
	// ******************************
	task automatic write_reg(input logic [31:0] addr, input logic [31:0] data,
		input plic_pkg::axi_resp_t exp_resp, input string name);
		int delay;
		awaddr = addr[`PLIC_ADDR_BITS-1:0];
		wdata = data;
		wstrb = 4'hf;
		awvalid = 1'b1;
		wvalid = 1'b1;
		tick();
		while (!awready)
			tick();
		assert (wready) else
		begin
			proto_count++;
			$display("wready did not rise together with awready at %0t", $time);
		end
		tick();
		awvalid = 1'b0;
		wvalid = 1'b0;
		delay = $unsigned($random(seed)) % (max_delay + 1);
		repeat (delay)
		begin
			assert (bvalid) else
			begin
				proto_count++;
				$display("write response dropped before bready at %0t", $time);
			end
			tick();
		end
		assert (bvalid) else
		begin
			proto_count++;
			$display("write response never arrived at %0t", $time);
		end
		expect_val({name, " bresp"}, bresp, exp_resp);
		bready = 1'b1;
		tick();
		bready = 1'b0;
		assert (!bvalid) else
		begin
			proto_count++;
			$display("write response repeated after bready at %0t", $time);
		end
	endtask

	task automatic read_reg(input logic [31:0] addr, input logic [31:0] exp_data,
		input plic_pkg::axi_resp_t exp_resp, input string name);
		int delay;
		araddr = addr[`PLIC_ADDR_BITS-1:0];
		arvalid = 1'b1;
		tick();
		while (!arready)
			tick();
		tick();
		arvalid = 1'b0;
		delay = $unsigned($random(seed)) % (max_delay + 1);
		repeat (delay)
		begin
			assert (rvalid) else
			begin
				proto_count++;
				$display("read response dropped before rready at %0t", $time);
			end
			tick();
		end
		assert (rvalid) else
		begin
			proto_count++;
			$display("read response never arrived at %0t", $time);
		end
		expect_val(name, rdata, exp_data);
		expect_val({name, " rresp"}, rresp, exp_resp);
		rready = 1'b1;
		tick();
		rready = 1'b0;
		assert (!rvalid) else
		begin
			proto_count++;
			$display("read response repeated after rready at %0t", $time);
		end
	endtask

	task automatic set_prio(input int id, input logic [`PLIC_PRIO_BITS-1:0] val);
		write_reg(`PLIC_OFS_PRIO + id * 4, 32'(val), plic_pkg::OKAY, "priority write");
		m_prio[id] = val;
	endtask

	task automatic set_enable(input logic [31:0] val);
		write_reg(`PLIC_OFS_ENABLE, val, plic_pkg::OKAY, "enable write");
		m_enable = val & ~32'h1;
	endtask

	task automatic set_threshold(input logic [`PLIC_PRIO_BITS-1:0] val);
		write_reg(`PLIC_OFS_THRESHOLD, 32'(val), plic_pkg::OKAY, "threshold write");
		m_threshold = val;
	endtask

	task automatic send_complete(input int id);
		write_reg(`PLIC_OFS_CLAIM, id, plic_pkg::OKAY, "complete");
		if (m_enable[id])
			m_in_service[id] = 1'b0;
	endtask

	task automatic check_irq();
		logic irq_exp;
		void'(best_source(m_pending, m_enable, m_prio, m_threshold, irq_exp));
		expect_val("hart_irq", hart_irq, irq_exp);
	endtask

	task automatic claim_check();
		logic irq_exp;
		logic [4:0] id;
		id = best_source(m_pending, m_enable, m_prio, m_threshold, irq_exp);
		read_reg(`PLIC_OFS_CLAIM, 32'(id), plic_pkg::OKAY, "claim");
		if (id != 0)
		begin
			m_pending[id] = 1'b0;
			m_in_service[id] = 1'b1;
		end
	endtask

	task automatic check_pending();
		read_reg(`PLIC_OFS_PENDING, m_pending, plic_pkg::OKAY, "pending");
	endtask

	// One line alone must land on the bit the source map gives
	task automatic map_check(input int grp, input int idx, input int exp_id);
		set_line(grp, idx, 1'b1);
		m_line[exp_id] = 1'b1;
		settle();
		read_reg(`PLIC_OFS_PENDING, 32'h1 << exp_id, plic_pkg::OKAY, "pending map");
		check_irq();
		claim_check();
		set_line(grp, idx, 1'b0);
		m_line[exp_id] = 1'b0;
		settle();
		send_complete(exp_id);
		settle();
		read_reg(`PLIC_OFS_PENDING, 32'h0, plic_pkg::OKAY, "pending map cleared");
	endtask

	// ******************************
	// Compare process
	// ******************************
	initial
	begin : compare
		string name;
		logic [31:0] got;
		logic [31:0] exp;
		forever
		begin
			@(negedge clk);
			while (got_q.size() != 0)
			begin
				name = name_q.pop_front();
				got = got_q.pop_front();
				exp = exp_q.pop_front();
				assert (got === exp) else
				begin
					mismatch_count++;
					$display("mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
				end
			end
		end
	end

	initial
	begin
		repeat (NUM_STEPS * 200) @(posedge clk);
		$display("timeout: tests did not finish within %0d cycles", NUM_STEPS * 200);
		$display("** FAIL **");
		$finish;
	end

	// ******************************
	// Test sequence
	// ******************************
	initial
	begin
		seed = 32'ha338_50cc;
		max_delay = 3;
		mismatch_count = 0;
		proto_count = 0;
		rst = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = 4'h0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		uart_irq = '0;
		spi_irq = 1'b0;
		i2c_irq = '0;
		gpio_irq = '0;
		user_irq = '0;
		reset_dut();

		// Register readback and error responses
		for (int i = 1; i < `PLIC_NUM_SRC; i++)
			set_prio(i, $random(seed));
		for (int i = 1; i < `PLIC_NUM_SRC; i++)
			read_reg(`PLIC_OFS_PRIO + i * 4, 32'(m_prio[i]), plic_pkg::OKAY, "priority");
		set_enable($random(seed));
		read_reg(`PLIC_OFS_ENABLE, m_enable, plic_pkg::OKAY, "enable");
		set_threshold(5);
		read_reg(`PLIC_OFS_THRESHOLD, 32'd5, plic_pkg::OKAY, "threshold");
		read_reg(32'h300, 32'h0, plic_pkg::SLVERR, "unmapped read");
		write_reg(32'h300, 32'h1, plic_pkg::SLVERR, "unmapped write");
		write_reg(`PLIC_OFS_PRIO, 32'h3, plic_pkg::SLVERR, "priority 0 write");
		read_reg(`PLIC_OFS_PRIO, 32'h0, plic_pkg::OKAY, "priority 0");

		// Source map
		reset_dut();
		set_enable(32'hffff_ffff);
		for (int i = 1; i < `PLIC_NUM_SRC; i++)
			set_prio(i, 1);
		for (int i = 0; i < 4; i++)
			map_check(0, i, `PLIC_MAP_UART_LO + i);
		map_check(1, 0, `PLIC_MAP_SPI);
		for (int i = 0; i < 2; i++)
			map_check(2, i, `PLIC_MAP_I2C_LO + i);
		for (int i = 0; i < 8; i++)
			map_check(3, i, `PLIC_MAP_GPIO_LO + i);
		for (int i = 0; i < 16; i++)
			map_check(4, i, `PLIC_MAP_USER_LO + i);

		// Arbitration and threshold over random sets
		for (int r = 0; r < ARB_ROUNDS; r++)
		begin
			reset_dut();
			for (int i = 1; i < `PLIC_NUM_SRC; i++)
				set_prio(i, $random(seed));
			set_enable($random(seed));
			set_threshold($random(seed));
			apply_lines($random(seed));
			settle();
			check_pending();
			check_irq();
			repeat (4)
			begin
				claim_check();
				settle();
				check_irq();
			end
		end

		// Threshold sweep with one source at priority 4
		reset_dut();
		set_prio(9, 4);
		set_enable(32'hffff_ffff);
		set_src(9, 1'b1);
		for (int t = 0; t < 8; t++)
		begin
			set_threshold(t);
			settle();
			check_irq();
		end

		// Claim and complete with a line held high
		reset_dut();
		set_prio(3, 2);
		set_enable(32'hffff_ffff);
		set_src(3, 1'b1);
		settle();
		check_pending();
		check_irq();
		claim_check();
		settle();
		check_pending();
		check_irq();
		send_complete(3);
		settle();
		check_pending();
		check_irq();
		claim_check();
		set_enable(32'h0);
		send_complete(3);
		set_enable(32'hffff_ffff);
		settle();
		check_pending();
		check_irq();
		send_complete(3);
		settle();
		check_pending();
		check_irq();

		// Long response stalls
		max_delay = 12;
		for (int k = 0; k < BP_ROUNDS; k++)
		begin
			set_threshold($random(seed));
			read_reg(`PLIC_OFS_THRESHOLD, 32'(m_threshold), plic_pkg::OKAY, "threshold stall");
		end
		max_delay = 3;

		while (got_q.size() != 0)
			tick();
		$display("errors: %0d value mismatches, %0d protocol errors", mismatch_count,
			proto_count);
		if ((mismatch_count == 0) && (proto_count == 0))
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

/* flist.f */
+incdir+include
logic/plic_pkg.sv
logic/irq_synchronizer.sv
logic/plic_gateway.sv
logic/plic_target.sv
logic/plic_axil_regs.sv
logic/plic_top.sv
verification/plic_tb.sv

/* Bender.yml */
package:
  name: plic

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/plic_pkg.sv
      - logic/irq_synchronizer.sv
      - logic/plic_gateway.sv
      - logic/plic_target.sv
      - logic/plic_axil_regs.sv
      - logic/plic_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - verification/plic_tb.sv
